// File: common/udp_mux_settings.svh
// UDP mux build settings

`ifndef UDP_MUX_SETTINGS_SVH
`define UDP_MUX_SETTINGS_SVH

// number of frame sources feeding the mux
`define UDP_MUX_PORTS 4

// payload stream width in bits, one byte per beat
`define UDP_MUX_DATA_WIDTH 8

`endif

// File: common/udp_mux_pkg.sv
// UDP mux shared types

`default_nettype none

`include "udp_mux_settings.svh"

package udp_mux_pkg;

    // source index and one-hot source vector
    typedef logic [$clog2(`UDP_MUX_PORTS)-1:0] port_sel_t;
    typedef logic [`UDP_MUX_PORTS-1:0] port_mask_t;

    typedef logic [`UDP_MUX_DATA_WIDTH-1:0] payload_data_t;

    // IP addresses followed by the four UDP header words
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // idle waits for a header, active forwards payload until last
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

`default_nettype wire

// File: common/payload_if.sv
// Payload stream interface

`default_nettype none

interface payload_if
    import udp_mux_pkg::*;
();

    payload_data_t data;
    logic          valid;
    logic          ready;
    logic          last;
    // single error flag carried with the beat
    logic          user;

    modport source (
        output data, valid, last, user,
        input  ready
    );

    modport sink (
        input  data, valid, last, user,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/skid_buffer.sv
// Payload skid buffer

`default_nettype none

module skid_buffer
    import udp_mux_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    payload_if.sink       in,
    output payload_data_t m_data,
    output logic          m_valid,
    input  logic          m_ready,
    output logic          m_last,
    output logic          m_user
);

    logic          in_ready_reg;
    logic          out_valid_next;
    logic          tmp_valid;
    logic          tmp_valid_next;
    payload_data_t tmp_data;
    logic          tmp_last;
    logic          tmp_user;
    logic          store_in_to_out;
    logic          store_in_to_tmp;
    logic          store_tmp_to_out;

    // ready next cycle unless the temp slot could fill up
    assign in.ready = m_ready || (!tmp_valid && (!m_valid || !in.valid));

    always_comb begin
        out_valid_next   = m_valid;
        tmp_valid_next   = tmp_valid;
        store_in_to_out  = 1'b0;
        store_in_to_tmp  = 1'b0;
        store_tmp_to_out = 1'b0;
        if (in_ready_reg) begin
            if (m_ready || !m_valid) begin
                // output slot free, go straight through
                out_valid_next  = in.valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_next  = in.valid;
                store_in_to_tmp = 1'b1;
            end
        end else if (m_ready) begin
            // drain the parked beat
            out_valid_next   = tmp_valid;
            tmp_valid_next   = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid      <= 1'b0;
            tmp_valid    <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            m_valid      <= out_valid_next;
            tmp_valid    <= tmp_valid_next;
            in_ready_reg <= in.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_data <= in.data;
            m_last <= in.last;
            m_user <= in.user;
        end else if (store_tmp_to_out) begin
            m_data <= tmp_data;
            m_last <= tmp_last;
            m_user <= tmp_user;
        end
        if (store_in_to_tmp) begin
            tmp_data <= in.data;
            tmp_last <= in.last;
            tmp_user <= in.user;
        end
    end

endmodule

`default_nettype wire

// File: udp_mux/frame_control.sv
// Frame control FSM

`default_nettype none

module frame_control
    import udp_mux_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  port_sel_t  select,
    input  port_mask_t hdr_valid,
    input  logic       hdr_pending,
    input  logic       buf_ready,
    input  logic       last_beat,
    output port_mask_t hdr_ready,
    output logic       capture,
    output port_sel_t  sel,
    output port_mask_t payload_grant
);

    frame_state_t state;
    frame_state_t state_next;
    port_sel_t    sel_reg;
    port_mask_t   grant_next;

    // take a header only between frames and once the output slot is free
    assign capture = (state == FRAME_IDLE) && enable && !hdr_pending && hdr_valid[select];

    // the header register needs the new select in the accept cycle itself
    assign sel = capture ? select : sel_reg;

    always_comb begin
        state_next = state;
        case (state)
            FRAME_IDLE: begin
                if (capture) begin
                    state_next = FRAME_ACTIVE;
                end
            end
            FRAME_ACTIVE: begin
                if (last_beat) begin
                    state_next = FRAME_IDLE;
                end
            end
            default: begin
                state_next = FRAME_IDLE;
            end
        endcase
    end

    // ready goes back on the latched source only while the frame continues
    always_comb begin
        grant_next = '0;
        if (buf_ready && (state_next == FRAME_ACTIVE)) begin
            grant_next = port_mask_t'(1) << sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FRAME_IDLE;
            sel_reg       <= '0;
            hdr_ready     <= '0;
            payload_grant <= '0;
        end else begin
            state         <= state_next;
            sel_reg       <= sel;
            // one-cycle ready pulse on the accepted source
            hdr_ready     <= capture ? (port_mask_t'(1) << select) : '0;
            payload_grant <= grant_next;
        end
    end

endmodule

`default_nettype wire

// File: udp_mux/header_register.sv
// Output header register

`default_nettype none

`include "udp_mux_settings.svh"

module header_register
    import udp_mux_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          capture,
    input  port_sel_t                     sel,
    input  udp_hdr_t [`UDP_MUX_PORTS-1:0] hdr_in,
    input  logic                          hdr_ready,
    output logic                          hdr_valid,
    output udp_hdr_t                      hdr_out
);

    logic hdr_valid_next;

    // valid stays up until the downstream side takes the header
    always_comb begin
        hdr_valid_next = hdr_valid && !hdr_ready;
        if (capture) begin
            hdr_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= hdr_valid_next;
        end
    end

    // fields only change on a capture, so they hold through back-pressure
    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_out <= hdr_in[sel];
        end
    end

endmodule

`default_nettype wire

// File: udp_mux/payload_select.sv
// Payload source select

`default_nettype none

`include "udp_mux_settings.svh"

module payload_select
    import udp_mux_pkg::*;
(
    input  port_sel_t                          sel,
    input  port_mask_t                         grant,
    input  payload_data_t [`UDP_MUX_PORTS-1:0] tdata,
    input  port_mask_t                         tvalid,
    input  port_mask_t                         tlast,
    input  port_mask_t                         tuser,
    payload_if.source                          out,
    output logic                               last_beat
);

    logic beat;

    // grant is the registered tready, so valid and grant together is a transfer
    assign beat = tvalid[sel] && grant[sel];

    assign out.data  = tdata[sel];
    assign out.valid = beat;
    assign out.last  = tlast[sel];
    assign out.user  = tuser[sel];

    // ends the frame in the control FSM
    assign last_beat = beat && tlast[sel];

endmodule

`default_nettype wire

// File: udp_mux/udp_mux.sv
// UDP frame multiplexer

`default_nettype none

`include "udp_mux_settings.svh"

module udp_mux
    import udp_mux_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               enable,
    input  port_sel_t                          select,
    input  port_mask_t                         s_hdr_valid,
    output port_mask_t                         s_hdr_ready,
    input  logic [`UDP_MUX_PORTS-1:0][31:0]    s_ip_source_ip,
    input  logic [`UDP_MUX_PORTS-1:0][31:0]    s_ip_dest_ip,
    input  logic [`UDP_MUX_PORTS-1:0][15:0]    s_udp_source_port,
    input  logic [`UDP_MUX_PORTS-1:0][15:0]    s_udp_dest_port,
    input  logic [`UDP_MUX_PORTS-1:0][15:0]    s_udp_length,
    input  logic [`UDP_MUX_PORTS-1:0][15:0]    s_udp_checksum,
    input  payload_data_t [`UDP_MUX_PORTS-1:0] s_payload_tdata,
    input  port_mask_t                         s_payload_tvalid,
    output port_mask_t                         s_payload_tready,
    input  port_mask_t                         s_payload_tlast,
    input  port_mask_t                         s_payload_tuser,
    output logic                               m_hdr_valid,
    input  logic                               m_hdr_ready,
    output logic [31:0]                        m_ip_source_ip,
    output logic [31:0]                        m_ip_dest_ip,
    output logic [15:0]                        m_udp_source_port,
    output logic [15:0]                        m_udp_dest_port,
    output logic [15:0]                        m_udp_length,
    output logic [15:0]                        m_udp_checksum,
    output payload_data_t                      m_payload_tdata,
    output logic                               m_payload_tvalid,
    input  logic                               m_payload_tready,
    output logic                               m_payload_tlast,
    output logic                               m_payload_tuser
);

    udp_hdr_t [`UDP_MUX_PORTS-1:0] hdr_in;
    udp_hdr_t                      hdr_out;
    logic                          capture;
    port_sel_t                     sel;
    logic                          last_beat;

    payload_if payload_bus ();

    // gather each source's loose fields into one header word
    always_comb begin
        for (int i = 0; i < `UDP_MUX_PORTS; i++) begin
            hdr_in[i].source_ip   = s_ip_source_ip[i];
            hdr_in[i].dest_ip     = s_ip_dest_ip[i];
            hdr_in[i].source_port = s_udp_source_port[i];
            hdr_in[i].dest_port   = s_udp_dest_port[i];
            hdr_in[i].length      = s_udp_length[i];
            hdr_in[i].checksum    = s_udp_checksum[i];
        end
    end

    frame_control u_frame_control (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .select        (select),
        .hdr_valid     (s_hdr_valid),
        .hdr_pending   (m_hdr_valid),
        .buf_ready     (payload_bus.ready),
        .last_beat     (last_beat),
        .hdr_ready     (s_hdr_ready),
        .capture       (capture),
        .sel           (sel),
        .payload_grant (s_payload_tready)
    );

    header_register u_header_register (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .sel       (sel),
        .hdr_in    (hdr_in),
        .hdr_ready (m_hdr_ready),
        .hdr_valid (m_hdr_valid),
        .hdr_out   (hdr_out)
    );

    payload_select u_payload_select (
        .sel       (sel),
        .grant     (s_payload_tready),
        .tdata     (s_payload_tdata),
        .tvalid    (s_payload_tvalid),
        .tlast     (s_payload_tlast),
        .tuser     (s_payload_tuser),
        .out       (payload_bus.source),
        .last_beat (last_beat)
    );

    skid_buffer u_skid_buffer (
        .clk     (clk),
        .rst     (rst),
        .in      (payload_bus.sink),
        .m_data  (m_payload_tdata),
        .m_valid (m_payload_tvalid),
        .m_ready (m_payload_tready),
        .m_last  (m_payload_tlast),
        .m_user  (m_payload_tuser)
    );

    assign m_ip_source_ip    = hdr_out.source_ip;
    assign m_ip_dest_ip      = hdr_out.dest_ip;
    assign m_udp_source_port = hdr_out.source_port;
    assign m_udp_dest_port   = hdr_out.dest_port;
    assign m_udp_length      = hdr_out.length;
    assign m_udp_checksum    = hdr_out.checksum;

endmodule

`default_nettype wire

// File: tests/udp_mux_tasks.svh
// UDP mux directed tests

`ifndef UDP_MUX_TASKS_SVH
`define UDP_MUX_TASKS_SVH

function automatic udp_hdr_t make_header(input int p, input int tag);
    udp_hdr_t h;
    h.source_ip   = {8'h0a, 8'(p), 8'(tag), 8'h01};
    h.dest_ip     = {8'hc0, 8'ha8, 8'(tag), 8'(p + 16)};
    h.source_port = {8'(p), 8'(tag)};
    h.dest_port   = 16'h1000 + 16'(tag);
    h.length      = 16'(8 + tag);
    h.checksum    = {8'(tag), 8'(p) ^ 8'h5a};
    return h;
endfunction

task automatic drive_header(input int p, input udp_hdr_t h);
    select               = port_sel_t'(p);
    s_ip_source_ip[p]    = h.source_ip;
    s_ip_dest_ip[p]      = h.dest_ip;
    s_udp_source_port[p] = h.source_port;
    s_udp_dest_port[p]   = h.dest_port;
    s_udp_length[p]      = h.length;
    s_udp_checksum[p]    = h.checksum;
    s_hdr_valid[p]       = 1'b1;
endtask

// source side holds valid until its ready bit shows
task automatic offer_header(input int p, input udp_hdr_t h);
    int cnt;
    cnt = 0;
    drive_header(p, h);
    do begin
        @(negedge clk);
        cnt++;
        if (cnt > WAIT_LIMIT) begin
            timed_out("header ready");
        end
    end while (!s_hdr_ready[p]);
    @(posedge clk);
    #1;
    s_hdr_valid[p] = 1'b0;
endtask

task automatic take_header(input udp_hdr_t h);
    int cnt;
    cnt = 0;
    m_hdr_ready = 1'b1;
    do begin
        @(negedge clk);
        cnt++;
        if (cnt > WAIT_LIMIT) begin
            timed_out("output header valid");
        end
    end while (!m_hdr_valid);
    check(128'({m_ip_source_ip, m_ip_dest_ip, m_udp_source_port, m_udp_dest_port,
                m_udp_length, m_udp_checksum}), 128'(h), "output header fields");
    @(posedge clk);
    #1;
    m_hdr_ready = 1'b0;
endtask

// bp makes the output ready follow LFSR bits
task automatic stream_payload(input int p, input int n, input bit bp);
    for (int i = 0; i < n; i++) begin
        tx_bytes[i] = lfsr_byte();
    end
    fork
        begin
            int cnt;
            for (int i = 0; i < n; i++) begin
                s_payload_tdata[p]  = tx_bytes[i];
                s_payload_tvalid[p] = 1'b1;
                s_payload_tlast[p]  = (i == n - 1);
                s_payload_tuser[p]  = (i == n - 1);
                cnt = 0;
                do begin
                    @(negedge clk);
                    cnt++;
                    if (cnt > WAIT_LIMIT) begin
                        timed_out("payload input ready");
                    end
                end while (!s_payload_tready[p]);
                @(posedge clk);
                #1;
            end
            s_payload_tvalid[p] = 1'b0;
            s_payload_tlast[p]  = 1'b0;
            s_payload_tuser[p]  = 1'b0;
        end
        begin
            int got;
            int cnt;
            got = 0;
            cnt = 0;
            while (got < n) begin
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT) begin
                    timed_out("payload output beat");
                end
                if (m_payload_tvalid && m_payload_tready) begin
                    check(128'(m_payload_tdata), 128'(tx_bytes[got]), "payload byte");
                    check(128'(m_payload_tlast), 128'(got == n - 1), "payload tlast");
                    check(128'(m_payload_tuser), 128'(got == n - 1), "payload tuser");
                    got++;
                end
                @(posedge clk);
                #1;
                m_payload_tready = bp ? lfsr_bit() : 1'b1;
            end
        end
    join
    // the final beat has left, so nothing may follow it
    check(128'(m_payload_tvalid), 128'(0), "extra payload beat after last");
    m_payload_tready = 1'b1;
endtask

task automatic run_frame(input int p, input udp_hdr_t h, input int n, input bit bp);
    allowed = port_mask_t'(1) << p;
    fork
        offer_header(p, h);
        take_header(h);
    join
    stream_payload(p, n, bp);
endtask

task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk);
    check(128'(s_hdr_ready), 128'(0), "s_hdr_ready after reset");
    check(128'(s_payload_tready), 128'(0), "s_payload_tready after reset");
    check(128'(m_hdr_valid), 128'(0), "m_hdr_valid after reset");
    check(128'(m_payload_tvalid), 128'(0), "m_payload_tvalid after reset");
    @(posedge clk);
    #1;
    report_test("reset", e0);
endtask

task automatic test_single_frame();
    int e0;
    e0 = errors;
    run_frame(0, make_header(0, 1), 6, 1'b0);
    report_test("single frame", e0);
endtask

task automatic test_all_ports();
    int e0;
    e0 = errors;
    for (int p = 0; p < `UDP_MUX_PORTS; p++) begin
        run_frame(p, make_header(p, p + 2), 4 + p, 1'b0);
    end
    report_test("all ports", e0);
endtask

task automatic test_enable();
    int e0;
    udp_hdr_t h;
    e0 = errors;
    h = make_header(2, 7);
    allowed = 4'b0100;
    enable = 1'b0;
    drive_header(2, h);
    repeat (20) begin
        @(negedge clk);
        check(128'(s_hdr_ready[2]), 128'(0), "header ready while enable is low");
    end
    @(posedge clk);
    #1;
    enable = 1'b1;
    run_frame(2, h, 5, 1'b0);
    report_test("enable", e0);
endtask

task automatic test_payload_backpressure();
    int e0;
    e0 = errors;
    run_frame(3, make_header(3, 9), 16, 1'b1);
    report_test("payload back-pressure", e0);
endtask

task automatic test_header_backpressure();
    int e0;
    udp_hdr_t h1;
    udp_hdr_t h2;
    e0 = errors;
    h1 = make_header(0, 11);
    h2 = make_header(1, 12);
    allowed = 4'b0001;
    offer_header(0, h1);
    stream_payload(0, 4, 1'b0);
    allowed = 4'b0010;
    drive_header(1, h2);
    repeat (10) begin
        @(negedge clk);
        check(128'(s_hdr_ready[1]), 128'(0), "second header ready while first pending");
        check(128'(m_hdr_valid), 128'(1), "first header valid held");
        check(128'({m_ip_source_ip, m_ip_dest_ip, m_udp_source_port, m_udp_dest_port,
                    m_udp_length, m_udp_checksum}), 128'(h1), "first header held stable");
    end
    @(posedge clk);
    #1;
    take_header(h1);
    run_frame(1, h2, 3, 1'b0);
    report_test("header back-pressure", e0);
endtask

`endif

// File: tests/tb_udp_mux.sv
// UDP mux testbench

`default_nettype none

`include "udp_mux_settings.svh"

module tb_udp_mux
    import udp_mux_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;

    logic                                clk;
    logic                                rst;
    logic                                enable;
    port_sel_t                           select;
    port_mask_t                          s_hdr_valid;
    port_mask_t                          s_hdr_ready;
    logic [`UDP_MUX_PORTS-1:0][31:0]     s_ip_source_ip;
    logic [`UDP_MUX_PORTS-1:0][31:0]     s_ip_dest_ip;
    logic [`UDP_MUX_PORTS-1:0][15:0]     s_udp_source_port;
    logic [`UDP_MUX_PORTS-1:0][15:0]     s_udp_dest_port;
    logic [`UDP_MUX_PORTS-1:0][15:0]     s_udp_length;
    logic [`UDP_MUX_PORTS-1:0][15:0]     s_udp_checksum;
    payload_data_t [`UDP_MUX_PORTS-1:0]  s_payload_tdata;
    port_mask_t                          s_payload_tvalid;
    port_mask_t                          s_payload_tready;
    port_mask_t                          s_payload_tlast;
    port_mask_t                          s_payload_tuser;
    logic                                m_hdr_valid;
    logic                                m_hdr_ready;
    logic [31:0]                         m_ip_source_ip;
    logic [31:0]                         m_ip_dest_ip;
    logic [15:0]                         m_udp_source_port;
    logic [15:0]                         m_udp_dest_port;
    logic [15:0]                         m_udp_length;
    logic [15:0]                         m_udp_checksum;
    payload_data_t                       m_payload_tdata;
    logic                                m_payload_tvalid;
    logic                                m_payload_tready;
    logic                                m_payload_tlast;
    logic                                m_payload_tuser;

    int            errors;
    int            tests_run;
    int            tests_failed;
    logic [15:0]   lfsr;
    // only the port under test may see a ready bit
    port_mask_t    allowed;
    payload_data_t tx_bytes [0:31];

    udp_mux u_udp_mux (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic payload_data_t lfsr_byte();
        payload_data_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display("test failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check(128'((s_hdr_ready | s_payload_tready) & ~allowed), 128'(0),
                  "ready on a port that is not selected");
        end
    end

    `include "udp_mux_tasks.svh"

    initial begin
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        lfsr             = 16'd64;
        allowed          = '0;
        rst              = 1'b1;
        enable           = 1'b1;
        select           = '0;
        s_hdr_valid      = '0;
        s_ip_source_ip   = '0;
        s_ip_dest_ip     = '0;
        s_udp_source_port = '0;
        s_udp_dest_port  = '0;
        s_udp_length     = '0;
        s_udp_checksum   = '0;
        s_payload_tdata  = '0;
        s_payload_tvalid = '0;
        s_payload_tlast  = '0;
        s_payload_tuser  = '0;
        m_hdr_ready      = 1'b0;
        m_payload_tready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_single_frame();
        test_all_ports();
        test_enable();
        test_payload_backpressure();
        test_header_backpressure();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
+incdir+tests
common/udp_mux_pkg.sv
common/payload_if.sv
logic/skid_buffer.sv
udp_mux/frame_control.sv
udp_mux/header_register.sv
udp_mux/payload_select.sv
udp_mux/udp_mux.sv
tests/tb_udp_mux.sv

// File: Makefile
# Verilator build and run for the UDP mux testbench

SIM = obj_dir/Vtb_udp_mux

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): src.f common/*.sv common/*.svh logic/*.sv udp_mux/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing -j 0 --top-module tb_udp_mux -f src.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "test failed" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
